// ==== Makefile ====
VERILATOR ?= verilator
FLAGS ?= --binary --assert -j 0 -Wno-fatal
TOP ?= tb_top
FILELIST ?= tb.f

PASS_MSG := SIMULATION PASSED
SIM := obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== hw/act_skew.sv ====
`timescale 1ns/1ps

module act_skew #(
	parameter int N = sa_geom_pkg::N,
	parameter int LANES = sa_geom_pkg::LANES
) (
	input logic clk,
	input logic arst_n,
	input logic act_valid,
	input logic [N*LANES*sa_geom_pkg::DATA_W-1:0] act_data,
	output logic [N*LANES*sa_geom_pkg::DATA_W-1:0] row_act,
	output logic [N-1:0] row_valid
);

	localparam int ROW_W = LANES * sa_geom_pkg::DATA_W;

	// row 0 goes straight in
	assign row_act[0 +: ROW_W] = act_data[0 +: ROW_W];
	assign row_valid[0] = act_valid;

	// row i gets i register stages
	for (genvar i = 1; i < N; i++) begin : g_row
		logic [ROW_W-1:0] data_q [i];
		logic [i-1:0] valid_q;

		always_ff @(posedge clk or negedge arst_n) begin
			if (!arst_n) begin
				valid_q <= '0;
			end else begin
				valid_q[0] <= act_valid;
				for (int k = 1; k < i; k++) begin
					valid_q[k] <= valid_q[k-1];
				end
			end
		end

		always_ff @(posedge clk) begin
			data_q[0] <= act_data[i*ROW_W +: ROW_W];
			for (int k = 1; k < i; k++) begin
				data_q[k] <= data_q[k-1];
			end
		end

		assign row_act[i*ROW_W +: ROW_W] = data_q[i-1];
		assign row_valid[i] = valid_q[i-1];
	end

endmodule

// ==== hw/mac_pe.sv ====
`timescale 1ns/1ps

module mac_pe #(
	parameter int LANES = sa_geom_pkg::LANES
) (
	input logic clk,
	input logic arst_n,
	input logic [sa_geom_pkg::DATA_W-1:0] weight,
	input logic [LANES*sa_geom_pkg::DATA_W-1:0] act_in,
	input logic [LANES*sa_geom_pkg::ACC_W-1:0] psum_in,
	output logic [LANES*sa_geom_pkg::DATA_W-1:0] act_out,
	output logic [LANES*sa_geom_pkg::ACC_W-1:0] psum_out
);

	localparam int DW = sa_geom_pkg::DATA_W;
	localparam int AW = sa_geom_pkg::ACC_W;
	localparam int PW = 2 * DW;

	logic [LANES*AW-1:0] psum_d;

	// same weight for every lane
	always_comb begin
		logic signed [PW-1:0] prod;
		for (int l = 0; l < LANES; l++) begin
			prod = $signed(act_in[l*DW +: DW]) * $signed(weight);
			// sign extend the product, sum wraps mod 2^32
			psum_d[l*AW +: AW] = psum_in[l*AW +: AW] + {{(AW - PW){prod[PW-1]}}, prod};
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			act_out <= '0;
			psum_out <= '0;
		end else begin
			// activations move one column right
			act_out <= act_in;
			psum_out <= psum_d;
		end
	end

endmodule

// ==== hw/pe_row.sv ====
`timescale 1ns/1ps

module pe_row #(
	parameter int N = sa_geom_pkg::N,
	parameter int LANES = sa_geom_pkg::LANES
) (
	input logic clk,
	input logic arst_n,
	input logic load_valid,
	input logic [N*sa_geom_pkg::DATA_W-1:0] wgt_in,
	output logic [N*sa_geom_pkg::DATA_W-1:0] wgt_out,
	input logic [LANES*sa_geom_pkg::DATA_W-1:0] act_in,
	input logic [N*LANES*sa_geom_pkg::ACC_W-1:0] psum_in,
	output logic [N*LANES*sa_geom_pkg::ACC_W-1:0] psum_out
);

	localparam int DW = sa_geom_pkg::DATA_W;
	localparam int LANE_W = LANES * DW;
	localparam int COL_W = LANES * sa_geom_pkg::ACC_W;

	logic [N*DW-1:0] wgt_q;
	// act_link[N] is what leaves the right edge of the row
	logic [LANE_W-1:0] act_link [N+1];

	// weights held here until the next load
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wgt_q <= '0;
		end else if (load_valid) begin
			wgt_q <= wgt_in;
		end
	end

	// the row below captures our old word on the same beat
	assign wgt_out = wgt_q;
	assign act_link[0] = act_in;

	for (genvar j = 0; j < N; j++) begin : g_pe
		mac_pe #(
			.LANES(LANES)
		) pe_i (
			.clk(clk),
			.arst_n(arst_n),
			.weight(wgt_q[j*DW +: DW]),
			.act_in(act_link[j]),
			.psum_in(psum_in[j*COL_W +: COL_W]),
			.act_out(act_link[j+1]),
			.psum_out(psum_out[j*COL_W +: COL_W])
		);
	end

endmodule

// ==== hw/result_deskew.sv ====
`timescale 1ns/1ps

module result_deskew #(
	parameter int N = sa_geom_pkg::N,
	parameter int LANES = sa_geom_pkg::LANES
) (
	input logic clk,
	input logic arst_n,
	input logic col_valid,
	input logic [N*LANES*sa_geom_pkg::ACC_W-1:0] col_psum,
	output logic res_valid,
	output logic [N*LANES*sa_geom_pkg::ACC_W-1:0] res_word
);

	localparam int COL_W = LANES * sa_geom_pkg::ACC_W;

	logic [N-1:0] vld_q;

	// col_valid is the bottom row's input valid
	// one stage for the bottom row, N-1 to line up with the last column
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= col_valid;
			for (int k = 1; k < N; k++) begin
				vld_q[k] <= vld_q[k-1];
			end
		end
	end

	assign res_valid = vld_q[N-1];

	// column j leaves the array j cycles after column 0
	for (genvar j = 0; j < N; j++) begin : g_col
		localparam int D = N - 1 - j;

		if (D == 0) begin : g_pass
			assign res_word[j*COL_W +: COL_W] = col_psum[j*COL_W +: COL_W];
		end else begin : g_dly
			logic [COL_W-1:0] pipe_q [D];

			always_ff @(posedge clk) begin
				pipe_q[0] <= col_psum[j*COL_W +: COL_W];
				for (int k = 1; k < D; k++) begin
					pipe_q[k] <= pipe_q[k-1];
				end
			end

			assign res_word[j*COL_W +: COL_W] = pipe_q[D-1];
		end
	end

endmodule

// ==== hw/result_queue.sv ====
`timescale 1ns/1ps

module result_queue #(
	parameter int RES_DEPTH = sa_flow_pkg::RES_DEPTH,
	parameter int OUT_CREDITS = sa_flow_pkg::OUT_CREDITS,
	parameter int WORD_W = sa_geom_pkg::RES_VEC_W
) (
	input logic clk,
	input logic arst_n,
	input logic wr_valid,
	input logic [WORD_W-1:0] wr_data,
	output logic res_valid,
	output logic [WORD_W-1:0] res_data,
	input logic res_credit,
	output logic act_credit
);

	localparam int PTR_W = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
	localparam int CNT_W = $clog2(RES_DEPTH + 1);
	localparam int CRD_W = $clog2(OUT_CREDITS + 1);

	logic [WORD_W-1:0] mem [RES_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] out_cred;
	logic pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(RES_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// the sender's credits keep the FIFO from overflowing
	assign pop = (count != '0) && (out_cred != '0);

	always_ff @(posedge clk) begin
		if (wr_valid) begin
			mem[wr_ptr] <= wr_data;
		end
		if (pop) begin
			res_data <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_cred <= CRD_W'(OUT_CREDITS);
			res_valid <= 1'b0;
			act_credit <= 1'b0;
		end else begin
			if (wr_valid) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end

			case ({wr_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase

			// spend one per result, get one back per res_credit
			case ({pop, res_credit})
				2'b10: out_cred <= out_cred - 1'b1;
				2'b01: out_cred <= out_cred + 1'b1;
				default: out_cred <= out_cred;
			endcase

			res_valid <= pop;
			// freed entry goes back to the sender
			act_credit <= pop;
		end
	end

endmodule

// ==== hw/sa_flow_pkg.sv ====
package sa_flow_pkg;

	// result FIFO entries, the sender starts with this many credits
	localparam int RES_DEPTH = 8;

	// credits the DUT holds on the result side after reset
	localparam int OUT_CREDITS = 4;

	// wide enough for either counter at the default depths
	localparam int CREDIT_W = 4;

endpackage

// ==== hw/sa_geom_pkg.sv ====
package sa_geom_pkg;

	// square array
	localparam int N = 4;

	// parallel lanes inside one processing element
	localparam int LANES = 4;

	// signed int8 operands, 32-bit partial sums
	localparam int DATA_W = 8;
	localparam int ACC_W = 32;

	// flattened buses, row or column outer, lane inner, lowest index in the lowest bits
	localparam int ACT_VEC_W = N * LANES * DATA_W;

	// one weight load beat, one byte per column
	localparam int WGT_WORD_W = N * DATA_W;

	// one aligned result, every column and lane
	localparam int RES_VEC_W = N * LANES * ACC_W;

endpackage

// ==== hw/systolic_array.sv ====
`timescale 1ns/1ps

module systolic_array #(
	parameter int N = sa_geom_pkg::N,
	parameter int LANES = sa_geom_pkg::LANES,
	parameter int RES_DEPTH = sa_flow_pkg::RES_DEPTH,
	parameter int OUT_CREDITS = sa_flow_pkg::OUT_CREDITS
) (
	input logic clk,
	input logic arst_n,
	input logic load_valid,
	input logic [N*sa_geom_pkg::DATA_W-1:0] load_word,
	input logic act_valid,
	input logic [N*LANES*sa_geom_pkg::DATA_W-1:0] act_data,
	input logic res_credit,
	output logic act_credit,
	output logic res_valid,
	output logic [N*LANES*sa_geom_pkg::ACC_W-1:0] res_data
);

	localparam int WGT_W = N * sa_geom_pkg::DATA_W;
	localparam int ROW_W = LANES * sa_geom_pkg::DATA_W;
	localparam int RES_W = N * LANES * sa_geom_pkg::ACC_W;

	logic [N*ROW_W-1:0] row_act;
	logic [N-1:0] row_valid;
	// wgt_link[N] falls off the bottom row
	logic [WGT_W-1:0] wgt_link [N+1];
	logic [RES_W-1:0] psum_link [N+1];
	logic dsk_valid;
	logic [RES_W-1:0] dsk_word;

	act_skew #(
		.N(N),
		.LANES(LANES)
	) skew_i (
		.clk(clk),
		.arst_n(arst_n),
		.act_valid(act_valid),
		.act_data(act_data),
		.row_act(row_act),
		.row_valid(row_valid)
	);

	// weights enter at the top, partial sums start from zero there
	assign wgt_link[0] = load_word;
	assign psum_link[0] = '0;

	for (genvar i = 0; i < N; i++) begin : g_row
		pe_row #(
			.N(N),
			.LANES(LANES)
		) row_i (
			.clk(clk),
			.arst_n(arst_n),
			.load_valid(load_valid),
			.wgt_in(wgt_link[i]),
			.wgt_out(wgt_link[i+1]),
			.act_in(row_act[i*ROW_W +: ROW_W]),
			.psum_in(psum_link[i]),
			.psum_out(psum_link[i+1])
		);
	end

	// bottom row valid, deskew adds the row stage
	result_deskew #(
		.N(N),
		.LANES(LANES)
	) deskew_i (
		.clk(clk),
		.arst_n(arst_n),
		.col_valid(row_valid[N-1]),
		.col_psum(psum_link[N]),
		.res_valid(dsk_valid),
		.res_word(dsk_word)
	);

	result_queue #(
		.RES_DEPTH(RES_DEPTH),
		.OUT_CREDITS(OUT_CREDITS),
		.WORD_W(RES_W)
	) queue_i (
		.clk(clk),
		.arst_n(arst_n),
		.wr_valid(dsk_valid),
		.wr_data(dsk_word),
		.res_valid(res_valid),
		.res_data(res_data),
		.res_credit(res_credit),
		.act_credit(act_credit)
	);

endmodule

// ==== tb.f ====
hw/sa_geom_pkg.sv
hw/sa_flow_pkg.sv
hw/mac_pe.sv
hw/pe_row.sv
hw/act_skew.sv
hw/result_deskew.sv
hw/result_queue.sv
hw/systolic_array.sv
tests/sa_sva.sv
tests/sa_checker.sv
tests/tb_top.sv

// ==== tests/sa_checker.sv ====
`timescale 1ns/1ps

module sa_checker #(
	parameter int N = sa_geom_pkg::N,
	parameter int LANES = sa_geom_pkg::LANES,
	parameter int RES_DEPTH = sa_flow_pkg::RES_DEPTH,
	parameter int OUT_CREDITS = sa_flow_pkg::OUT_CREDITS
) (
	input logic clk,
	input logic arst_n,
	input logic load_valid,
	input logic [N*sa_geom_pkg::DATA_W-1:0] load_word,
	input logic act_valid,
	input logic [N*LANES*sa_geom_pkg::DATA_W-1:0] act_data,
	input logic act_credit,
	input logic res_valid,
	input logic [N*LANES*sa_geom_pkg::ACC_W-1:0] res_data,
	input logic res_credit,
	input int test_id,
	input logic test_end,
	input logic run_done,
	output int err_total
);

	localparam int DW = sa_geom_pkg::DATA_W;
	localparam int AW = sa_geom_pkg::ACC_W;
	localparam int ACT_W = N * LANES * DW;
	localparam int RES_W = N * LANES * AW;

	// wgt[row][col]
	logic [DW-1:0] wgt [N][N];
	logic [RES_W-1:0] exp_q [$];
	int test_err, test_res, tests_run, tests_failed;
	int n_acc, n_res, n_act_credit, n_res_credit;

	function automatic string test_name(input int id);
		case (id)
			1: return "idle after reset";
			2: return "random batch, full credit";
			3: return "int8 extremes";
			4: return "weight reload";
			5: return "output back-pressure";
			6: return "credit balance";
			default: return "unknown";
		endcase
	endfunction

	// column j, lane l = sum over rows of act[i][l] * wgt[i][j], mod 2^32
	function automatic logic [RES_W-1:0] model_result(input logic [ACT_W-1:0] a);
		logic [RES_W-1:0] r;
		logic signed [AW-1:0] sum;
		logic signed [AW-1:0] x;
		logic signed [AW-1:0] w;
		for (int j = 0; j < N; j++) begin
			for (int l = 0; l < LANES; l++) begin
				sum = '0;
				for (int i = 0; i < N; i++) begin
					x = {{(AW - DW){a[(i*LANES+l)*DW+DW-1]}}, a[(i*LANES+l)*DW +: DW]};
					w = {{(AW - DW){wgt[i][j][DW-1]}}, wgt[i][j]};
					sum = sum + x * w;
				end
				r[(j*LANES+l)*AW +: AW] = sum;
			end
		end
		return r;
	endfunction

	task automatic value_error(input string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		test_err++;
		err_total++;
	endtask

	task automatic other_error(input string msg);
		$display("error at %0t ns: %s", $time, msg);
		test_err++;
		err_total++;
	endtask

	task automatic report_test(input int id);
		tests_run++;
		if (test_err != 0) begin
			tests_failed++;
		end
		$display("test %0d (%s): %s, %0d results checked, %0d errors",
			id, test_name(id), (test_err == 0) ? "pass" : "fail", test_res, test_err);
		test_err = 0;
		test_res = 0;
	endtask

	task automatic check_result();
		logic [RES_W-1:0] e;
		n_res++;
		test_res++;
		if (exp_q.size() == 0) begin
			other_error("a result arrived with no activation outstanding");
			return;
		end
		e = exp_q.pop_front();
		for (int k = 0; k < N * LANES; k++) begin
			if (res_data[k*AW +: AW] !== e[k*AW +: AW]) begin
				value_error($sformatf("result %0d col %0d lane %0d expected %0d got %0d",
					n_res, k / LANES, k % LANES, $signed(e[k*AW +: AW]),
					$signed(res_data[k*AW +: AW])));
			end
		end
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			exp_q.delete();
			for (int i = 0; i < N; i++) begin
				for (int j = 0; j < N; j++) begin
					wgt[i][j] = '0;
				end
			end
			{test_err, test_res, tests_run, tests_failed} = '0;
			{n_acc, n_res, n_act_credit, n_res_credit, err_total} = '0;
		end else begin
			// uses the weights already in place, a load on this edge lands later
			if (act_valid) begin
				exp_q.push_back(model_result(act_data));
				n_acc++;
			end
			if (load_valid) begin
				for (int i = N - 1; i > 0; i--) begin
					for (int j = 0; j < N; j++) begin
						wgt[i][j] = wgt[i-1][j];
					end
				end
				for (int j = 0; j < N; j++) begin
					wgt[0][j] = load_word[j*DW +: DW];
				end
			end
			n_act_credit += int'(act_credit);
			n_res_credit += int'(res_credit);
			if (res_valid) begin
				check_result();
			end
			if (n_res > n_res_credit + OUT_CREDITS) begin
				other_error("more results sent than output credits allow");
			end
			if (n_acc - n_res > RES_DEPTH) begin
				other_error("more activations outstanding than input credits allow");
			end
			if (test_id == 1 && (res_valid || act_credit)) begin
				other_error("res_valid or act_credit active before any activation");
			end
			if (test_end) begin
				report_test(test_id);
			end
			if (run_done) begin
				if (n_act_credit != n_res) begin
					other_error($sformatf("%0d act_credit pulses for %0d results",
						n_act_credit, n_res));
				end
				if (exp_q.size() != 0) begin
					other_error($sformatf("%0d expected results never arrived", exp_q.size()));
				end
				report_test(6);
				$display("summary: %0d tests, %0d passed, %0d failed, %0d results, %0d errors",
					tests_run, tests_run - tests_failed, tests_failed, n_res, err_total);
			end
		end
	end

endmodule

// ==== tests/sa_sva.sv ====
`timescale 1ns/1ps

module sa_sva #(
	parameter int RES_DEPTH = sa_flow_pkg::RES_DEPTH,
	parameter int OUT_CREDITS = sa_flow_pkg::OUT_CREDITS
) (
	input logic clk,
	input logic arst_n,
	input logic load_valid,
	input logic act_valid,
	input logic act_credit,
	input logic res_valid,
	input logic res_credit
);

	int out_cred;
	int snd_cred;
	// accepted activations whose result has not left yet
	int inflight;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_cred <= OUT_CREDITS;
			snd_cred <= RES_DEPTH;
			inflight <= 0;
		end else begin
			out_cred <= out_cred - int'(res_valid) + int'(res_credit);
			snd_cred <= snd_cred - int'(act_valid) + int'(act_credit);
			inflight <= inflight + int'(act_valid) - int'(res_valid);
		end
	end

	res_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
		res_valid |-> out_cred > 0)
		else $error("res_valid raised with no output credit left");

	credits_bounded: assert property (@(posedge clk) disable iff (!arst_n)
		out_cred <= OUT_CREDITS && snd_cred <= RES_DEPTH)
		else $error("credit count above its initial value");

	load_when_idle: assert property (@(posedge clk) disable iff (!arst_n)
		load_valid |-> inflight == 0)
		else $error("weight load while results are in flight");

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

	localparam int N = sa_geom_pkg::N;
	localparam int LANES = sa_geom_pkg::LANES;
	localparam int DW = sa_geom_pkg::DATA_W;
	localparam int RES_DEPTH = sa_flow_pkg::RES_DEPTH;
	localparam int OUT_CREDITS = sa_flow_pkg::OUT_CREDITS;
	localparam int CW = sa_flow_pkg::CREDIT_W;
	localparam int WGT_W = N * DW;
	localparam int ACT_W = N * LANES * DW;
	localparam int RES_W = N * LANES * sa_geom_pkg::ACC_W;

	localparam int RAND_VECS = 200;
	localparam int EDGE_VECS = 16;
	localparam int RELOAD_VECS = 40;
	localparam int STALL_VECS = 30;
	localparam int TIMEOUT = 40 * (RAND_VECS + EDGE_VECS + RELOAD_VECS + STALL_VECS + 3 * N)
		+ 1000;
	localparam logic [31:0] SEED = 32'h61ac_f1e0;

	logic clk, arst_n, load_valid, act_valid, res_credit;
	logic act_credit, res_valid, test_end, run_done;
	logic [WGT_W-1:0] load_word;
	logic [ACT_W-1:0] act_data;
	logic [RES_W-1:0] res_data;
	logic [CW-1:0] snd_cred;
	logic [31:0] rng, crd_rng;
	// 0 prompt, 1 random with pauses, 2 held back
	logic [1:0] credit_mode;
	int test_id, err_total, acc_count, rcv_count, crd_owed, pause_left, cycles;

	systolic_array #(
		.N(N),
		.LANES(LANES),
		.RES_DEPTH(RES_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) dut_i (
		.clk(clk),
		.arst_n(arst_n),
		.load_valid(load_valid),
		.load_word(load_word),
		.act_valid(act_valid),
		.act_data(act_data),
		.res_credit(res_credit),
		.act_credit(act_credit),
		.res_valid(res_valid),
		.res_data(res_data)
	);

	sa_checker #(
		.N(N),
		.LANES(LANES),
		.RES_DEPTH(RES_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) checker_i (
		.clk(clk),
		.arst_n(arst_n),
		.load_valid(load_valid),
		.load_word(load_word),
		.act_valid(act_valid),
		.act_data(act_data),
		.act_credit(act_credit),
		.res_valid(res_valid),
		.res_data(res_data),
		.res_credit(res_credit),
		.test_id(test_id),
		.test_end(test_end),
		.run_done(run_done),
		.err_total(err_total)
	);

	bind systolic_array sa_sva #(
		.RES_DEPTH(RES_DEPTH),
		.OUT_CREDITS(OUT_CREDITS)
	) sva_i (
		.clk(clk),
		.arst_n(arst_n),
		.load_valid(load_valid),
		.act_valid(act_valid),
		.act_credit(act_credit),
		.res_valid(res_valid),
		.res_credit(res_credit)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// edge mode keeps to -128, 127, -1 and 1
	task automatic rand_byte(input logic edge_vals, output logic [DW-1:0] b);
		rng = lcg_next(rng);
		if (!edge_vals) begin
			b = rng[31:24];
		end else begin
			case (rng[31:30])
				2'd0: b = 8'h80;
				2'd1: b = 8'h7f;
				2'd2: b = 8'hff;
				default: b = 8'h01;
			endcase
		end
	endtask

	task automatic send_vec(input logic [ACT_W-1:0] v);
		int avail;
		avail = 0;
		while (avail <= 0) begin
			@(posedge clk);
			// credits left once this edge has taken the beat on the bus
			avail = int'(snd_cred) - int'(act_valid) + int'(act_credit);
			if (avail <= 0) begin
				act_valid <= 1'b0;
			end
		end
		act_valid <= 1'b1;
		act_data <= v;
	endtask

	task automatic run_batch(input int count, input logic edge_vals);
		logic [ACT_W-1:0] v;
		logic [DW-1:0] b;
		for (int n = 0; n < count; n++) begin
			for (int k = 0; k < ACT_W / DW; k++) begin
				rand_byte(edge_vals, b);
				v[k*DW +: DW] = b;
			end
			send_vec(v);
		end
		@(posedge clk);
		act_valid <= 1'b0;
	endtask

	task automatic wait_idle();
		@(posedge clk);
		while (acc_count != rcv_count) begin
			@(posedge clk);
		end
	endtask

	// beat k ends up in row N-1-k
	task automatic load_weights(input logic edge_vals);
		logic [WGT_W-1:0] w;
		logic [DW-1:0] b;
		wait_idle();
		for (int k = 0; k < N; k++) begin
			for (int j = 0; j < N; j++) begin
				rand_byte(edge_vals, b);
				w[j*DW +: DW] = b;
			end
			load_valid <= 1'b1;
			load_word <= w;
			@(posedge clk);
		end
		load_valid <= 1'b0;
	endtask

	task automatic finish_test();
		wait_idle();
		test_end <= 1'b1;
		@(posedge clk);
		test_end <= 1'b0;
	endtask

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			snd_cred <= CW'(RES_DEPTH);
			acc_count <= 0;
			rcv_count <= 0;
		end else begin
			snd_cred <= snd_cred - CW'(act_valid) + CW'(act_credit);
			acc_count <= acc_count + int'(act_valid);
			rcv_count <= rcv_count + int'(res_valid);
		end
	end

	// credit return, never more than the results received
	always @(posedge clk) begin
		int owed;
		owed = crd_owed + int'(res_valid) - int'(res_credit);
		crd_rng = lcg_next(crd_rng);
		crd_owed <= arst_n ? owed : 0;
		if (!arst_n || credit_mode == 2'd2) begin
			res_credit <= 1'b0;
		end else if (credit_mode == 2'd0) begin
			res_credit <= (owed > 0);
		end else if (pause_left > 0) begin
			pause_left <= pause_left - 1;
			res_credit <= 1'b0;
		end else if (crd_rng[31:27] == 5'd0) begin
			pause_left <= 8 + int'(crd_rng[26:22]);
			res_credit <= 1'b0;
		end else begin
			res_credit <= (owed > 0) && crd_rng[20];
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		rng = SEED;
		crd_rng = SEED ^ 32'h5a5a_0f0f;
		{arst_n, load_valid, act_valid, res_credit, test_end, run_done} = '0;
		load_word = '0;
		act_data = '0;
		credit_mode = 2'd0;
		{test_id, crd_owed, pause_left, cycles} = '0;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		test_id <= 1;
		repeat (20) @(posedge clk);
		finish_test();

		test_id <= 2;
		load_weights(1'b0);
		run_batch(RAND_VECS, 1'b0);
		finish_test();

		test_id <= 3;
		load_weights(1'b1);
		send_vec({(ACT_W / DW){8'h80}});
		send_vec({(ACT_W / DW){8'h7f}});
		run_batch(EDGE_VECS - 2, 1'b1);
		finish_test();

		test_id <= 4;
		credit_mode <= 2'd1;
		load_weights(1'b0);
		run_batch(RELOAD_VECS, 1'b0);
		finish_test();

		// sender runs dry while credits are held back
		test_id <= 5;
		credit_mode <= 2'd2;
		fork
			run_batch(STALL_VECS, 1'b0);
			begin
				repeat (200) @(posedge clk);
				credit_mode <= 2'd1;
			end
		join
		finish_test();

		test_id <= 6;
		run_done <= 1'b1;
		@(posedge clk);
		run_done <= 1'b0;
		@(posedge clk);
		if (err_total == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
